/* design/ecc_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for secp256k1 Jacobian point doubling
// Field elements are assumed already reduced below P_MOD
// State names carry a DBL_ or MUL_ prefix so both enums can share one scope
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ecc_pkg;

  localparam int FE_W    = 256;   // Field element width
  localparam int EQ_W    = 4;     // Tag width, equations 0..14
  localparam int EQ_N    = 15;    // Steps in the doubling schedule
  localparam int MUL_LAT = FE_W;  // Multiplier steps, one per operand bit

  typedef logic [FE_W-1:0] fe_t;
  typedef logic [EQ_W-1:0] eq_tag_t;
  typedef logic            req_id_t;  // 0 = engine 0, 1 = engine 1

  // p = 2^256 - 2^32 - 977
  localparam fe_t P_MOD =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // Equations that go to the shared multiplier: 0,1,3,5,7,11,14
  localparam logic [EQ_N-1:0] MUL_EQ_MASK = 15'b100_1000_1010_1011;

  typedef struct packed {
    fe_t x;
    fe_t y;
    fe_t z;
  } jb_point_t;

  typedef struct packed {
    fe_t     a;
    fe_t     b;
    eq_tag_t tag;
  } mul_req_t;

  typedef struct packed {
    fe_t     prod;
    eq_tag_t tag;
    req_id_t id;
  } mul_rsp_t;

  typedef enum logic [1:0] {DBL_IDLE, DBL_RUN, DBL_DONE} dbl_state_t;
  typedef enum logic       {MUL_IDLE, MUL_BUSY} mul_state_t;

  // a + b mod p, one conditional correction
  function automatic fe_t mod_add(input fe_t x, input fe_t y);
    logic [FE_W:0] s;
    s = {1'b0, x} + {1'b0, y};
    if (s >= {1'b0, P_MOD}) s = s - {1'b0, P_MOD};
    return s[FE_W-1:0];
  endfunction

  // a - b mod p; wraps through 2^256 then adds p back on borrow
  function automatic fe_t mod_sub(input fe_t x, input fe_t y);
    fe_t d;
    d = x - y;
    if (x < y) d = d + P_MOD;
    return d;
  endfunction

endpackage

/* design/mod_mult.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-serial modular multiplier, a*b mod p, one operation in flight
// Operands must be below P_MOD; result strobes MUL_LAT+1 cycles after accept
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mod_mult
  import ecc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  mul_req_t i_req,
  input  logic     i_val,
  output logic     o_rdy,
  output mul_rsp_t o_rsp,
  output logic     o_rsp_val
);

  mul_state_t                       state;
  logic [$clog2(MUL_LAT+1)-1:0]     cnt;       // Steps done, MUL_LAT = finished
  fe_t                              acc, op_a, op_b;
  eq_tag_t                          tag;
  logic [FE_W+1:0]                  t_sum, t_red1, t_red2;
  logic                             accept;

  assign accept = (state == MUL_IDLE) && i_val && o_rdy;

  // 2*acc + a < 3p, so two subtractions always land below p
  always_comb begin
    t_sum  = {1'b0, acc, 1'b0} + (op_b[FE_W-1] ? {2'b00, op_a} : '0);
    t_red1 = (t_sum >= {2'b00, P_MOD}) ? t_sum - {2'b00, P_MOD} : t_sum;
    t_red2 = (t_red1 >= {2'b00, P_MOD}) ? t_red1 - {2'b00, P_MOD} : t_red1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= MUL_IDLE;
      o_rdy     <= 1'b0;
      o_rsp_val <= 1'b0;
      cnt       <= '0;
    end else begin
      o_rsp_val <= 1'b0;  // Single-cycle strobe
      case (state)
        MUL_IDLE: begin
          o_rdy <= 1'b1;  // Comes back one cycle after the strobe
          if (accept) begin
            o_rdy <= 1'b0;
            cnt   <= '0;
            state <= MUL_BUSY;
          end
        end
        MUL_BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == MUL_LAT) begin
            o_rsp_val <= 1'b1;
            state     <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      op_a <= i_req.a;
      op_b <= i_req.b;
      tag  <= i_req.tag;
      acc  <= '0;
    end else if ((state == MUL_BUSY) && (cnt != MUL_LAT)) begin
      acc  <= t_red2[FE_W-1:0];
      op_b <= op_b << 1;  // MSB first
    end
  end

  assign o_rsp.prod = acc;
  assign o_rsp.tag  = tag;
  assign o_rsp.id   = '0;  // Filled in by the arbiter

endmodule

/* design/mult_arbiter.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-way round-robin share of one multiplier, no added latency
// Assumes one operation in flight, so a single owner register is enough
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mult_arbiter
  import ecc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  mul_req_t i_req0,
  input  mul_req_t i_req1,
  input  logic     i_val0,
  input  logic     i_val1,
  output logic     o_rdy0,
  output logic     o_rdy1,
  output mul_req_t o_req,
  output logic     o_val,
  input  logic     i_rdy,
  input  mul_rsp_t i_rsp,
  input  logic     i_rsp_val,
  output mul_rsp_t o_rsp,
  output logic     o_rsp_val0,
  output logic     o_rsp_val1
);

  req_id_t prio;    // Engine that wins the next tie
  req_id_t gnt_id;  // Engine selected this cycle
  req_id_t fly_id;  // Owner of the operation in the multiplier
  logic    xfer;

  // Tie goes to prio, otherwise the only requester
  assign gnt_id = (i_val0 && i_val1) ? prio : req_id_t'(i_val1);

  assign o_req  = gnt_id ? i_req1 : i_req0;
  assign o_val  = i_val0 | i_val1;
  assign o_rdy0 = i_rdy & (gnt_id == 1'b0);  // Loser sees ready low and waits
  assign o_rdy1 = i_rdy & (gnt_id == 1'b1);
  assign xfer   = o_val & i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio   <= 1'b0;
      fly_id <= 1'b0;
    end else if (xfer) begin
      prio   <= ~gnt_id;  // Other engine first next time
      fly_id <= gnt_id;
    end
  end

  // Response data fans out to both, only the owner gets the strobe
  always_comb begin
    o_rsp    = i_rsp;
    o_rsp.id = fly_id;
  end

  assign o_rsp_val0 = i_rsp_val & (fly_id == 1'b0);
  assign o_rsp_val1 = i_rsp_val & (fly_id == 1'b1);

endmodule

/* design/point_dbl.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Jacobian point doubling engine, one point at a time
// z == 0 is the point at infinity and is returned unchanged
// Multiplier responses are always accepted while the engine runs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module point_dbl
  import ecc_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  jb_point_t i_p,
  input  logic      i_val,
  output logic      o_rdy,
  output jb_point_t o_p,
  output logic      o_val,
  input  logic      i_rdy,
  output mul_req_t  o_req,
  output logic      o_req_val,
  input  logic      i_req_rdy,
  input  mul_rsp_t  i_rsp,
  input  logic      i_rsp_val
);

  // Schedule, [n] = needs equation n
  //  0 A = y*y        1 B = x*A [0]      2 B = 4B [1]      3 C = A*A [0]
  //  4 C = 8C [3]     5 D = x*x          6 D = 3D [5]      7 X = D*D [6]
  //  8 E = 2B [2]     9 X = X-E [7,8]   10 Y = B-X [9,2]  11 Y = D*Y [10,6]
  // 12 Y = Y-C [11,4] 13 Z = 2y         14 Z = Z*z [13]
  dbl_state_t      state;
  logic [EQ_N-1:0] issued, valid;        // Started / finished equations
  logic [EQ_N-1:0] dep_ok, mul_can, sm_can;
  fe_t             tmp_a, tmp_b, tmp_c, tmp_d, tmp_e;
  jb_point_t       p_in;                 // Latched input point
  fe_t             mul_a, mul_b;
  eq_tag_t         mul_tag, sm_tag, cur_tag;
  logic            mul_go, sm_go, sm_busy, sm_last, accept;
  logic [1:0]      sm_step, cur_step;    // Doubling count for x4 / x8

  // Lowest set bit wins, which is the schedule's priority order
  function automatic eq_tag_t first_set(input logic [EQ_N-1:0] m);
    eq_tag_t idx;
    idx = '0;
    for (int k = EQ_N - 1; k >= 0; k--) begin
      if (m[k]) idx = eq_tag_t'(k);
    end
    return idx;
  endfunction

  always_comb begin
    dep_ok[0]  = 1'b1;
    dep_ok[1]  = valid[0];
    dep_ok[2]  = valid[1];
    dep_ok[3]  = valid[0];
    dep_ok[4]  = valid[3];
    dep_ok[5]  = 1'b1;
    dep_ok[6]  = valid[5];
    dep_ok[7]  = valid[6];
    dep_ok[8]  = valid[2];
    dep_ok[9]  = valid[7] & valid[8];
    dep_ok[10] = valid[9] & valid[2];
    dep_ok[11] = valid[10] & valid[6];
    dep_ok[12] = valid[11] & valid[4];
    dep_ok[13] = 1'b1;
    dep_ok[14] = valid[13];
  end

  assign accept  = (state == DBL_IDLE) && i_val && o_rdy;
  assign mul_can = dep_ok & ~issued & MUL_EQ_MASK;
  assign sm_can  = dep_ok & ~issued & ~MUL_EQ_MASK;
  assign mul_tag = first_set(mul_can);
  // New request only when the slot is empty or draining this cycle
  assign mul_go  = (state == DBL_RUN) && (|mul_can) && (!o_req_val || i_req_rdy);
  // A multi-cycle small op keeps the ALU until its last doubling
  assign sm_go    = (state == DBL_RUN) && (sm_busy || (|sm_can));
  assign cur_tag  = sm_busy ? sm_tag : first_set(sm_can);
  assign cur_step = sm_busy ? sm_step : 2'd0;
  assign sm_last  = (cur_tag == 4'd2) ? (cur_step == 2'd1) :
                    (cur_tag == 4'd4) ? (cur_step == 2'd2) : 1'b1;

  always_comb begin
    mul_a = p_in.y;  // Eq 0 default
    mul_b = p_in.y;
    case (mul_tag)
      4'd1: begin
        mul_a = p_in.x;
        mul_b = tmp_a;
      end
      4'd3: begin
        mul_a = tmp_a;
        mul_b = tmp_a;
      end
      4'd5: begin
        mul_a = p_in.x;
        mul_b = p_in.x;
      end
      4'd7: begin
        mul_a = tmp_d;
        mul_b = tmp_d;
      end
      4'd11: begin
        mul_a = tmp_d;
        mul_b = o_p.y;
      end
      4'd14: begin
        mul_a = o_p.z;
        mul_b = p_in.z;
      end
      default: ;
    endcase
  end

  // Control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= DBL_IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_req_val <= 1'b0;
      issued    <= '0;
      valid     <= '0;
      sm_busy   <= 1'b0;
      sm_tag    <= '0;
      sm_step   <= '0;
    end else begin
      case (state)
        DBL_IDLE: begin
          o_rdy <= 1'b1;
          if (accept) begin
            o_rdy   <= 1'b0;
            issued  <= '0;
            valid   <= '0;
            sm_busy <= 1'b0;
            if (i_p.z == '0) begin  // Infinity, straight to output
              o_val <= 1'b1;
              state <= DBL_DONE;
            end else begin
              state <= DBL_RUN;
            end
          end
        end
        DBL_RUN: if (&valid) begin
          o_val <= 1'b1;
          state <= DBL_DONE;
        end
        DBL_DONE: if (i_rdy) begin  // Hold until the result transfers
          o_val <= 1'b0;
          state <= DBL_IDLE;
        end
        default: state <= DBL_IDLE;
      endcase
      if (o_req_val && i_req_rdy) o_req_val <= 1'b0;
      if (mul_go) begin
        o_req_val        <= 1'b1;
        issued[mul_tag]  <= 1'b1;
      end
      if ((state == DBL_RUN) && i_rsp_val) valid[i_rsp.tag] <= 1'b1;
      if (sm_go) begin
        issued[cur_tag] <= 1'b1;
        sm_tag          <= cur_tag;
        sm_busy         <= !sm_last;
        sm_step         <= cur_step + 2'd1;
        if (sm_last) valid[cur_tag] <= 1'b1;
      end
    end
  end

  // Datapath
  always_ff @(posedge i_clk) begin
    if (accept) begin
      p_in <= i_p;
      o_p  <= i_p;  // Passes infinity through as is
    end
    if (mul_go) begin
      o_req.a   <= mul_a;
      o_req.b   <= mul_b;
      o_req.tag <= mul_tag;
    end
    if ((state == DBL_RUN) && i_rsp_val) begin
      case (i_rsp.tag)
        4'd0:    tmp_a <= i_rsp.prod;
        4'd1:    tmp_b <= i_rsp.prod;
        4'd3:    tmp_c <= i_rsp.prod;
        4'd5:    tmp_d <= i_rsp.prod;
        4'd7:    o_p.x <= i_rsp.prod;
        4'd11:   o_p.y <= i_rsp.prod;
        4'd14:   o_p.z <= i_rsp.prod;
        default: ;
      endcase
    end
    if (sm_go) begin
      case (cur_tag)
        4'd2:    tmp_b <= mod_add(tmp_b, tmp_b);  // x2 per step, two steps
        4'd4:    tmp_c <= mod_add(tmp_c, tmp_c);  // Three steps
        4'd6:    tmp_d <= mod_add(mod_add(tmp_d, tmp_d), tmp_d);
        4'd8:    tmp_e <= mod_add(tmp_b, tmp_b);
        4'd9:    o_p.x <= mod_sub(o_p.x, tmp_e);
        4'd10:   o_p.y <= mod_sub(tmp_b, o_p.x);
        4'd12:   o_p.y <= mod_sub(o_p.y, tmp_c);
        4'd13:   o_p.z <= mod_add(p_in.y, p_in.y);
        default: ;
      endcase
    end
  end

endmodule

/* design/ecc_dbl_top.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two doubling engines sharing one modular multiplier
// Latency per port depends on contention; o_valN marks each result
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ecc_dbl_top
  import ecc_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  jb_point_t i_p0,
  input  logic      i_val0,
  output logic      o_rdy0,
  output jb_point_t o_p0,
  output logic      o_val0,
  input  logic      i_rdy0,
  input  jb_point_t i_p1,
  input  logic      i_val1,
  output logic      o_rdy1,
  output jb_point_t o_p1,
  output logic      o_val1,
  input  logic      i_rdy1
);

  mul_req_t req0, req1, arb_req;            // Engine requests, granted request
  logic     req_val0, req_val1, req_rdy0, req_rdy1;
  logic     arb_val, mul_rdy;
  mul_rsp_t mul_rsp, arb_rsp;               // Raw product, product with owner id
  logic     mul_rsp_val, rsp_val0, rsp_val1;

  point_dbl u_dbl0 (
    .i_clk, .i_rst, .i_p(i_p0), .i_val(i_val0), .o_rdy(o_rdy0),
    .o_p(o_p0), .o_val(o_val0), .i_rdy(i_rdy0),
    .o_req(req0), .o_req_val(req_val0), .i_req_rdy(req_rdy0),
    .i_rsp(arb_rsp), .i_rsp_val(rsp_val0)
  );

  point_dbl u_dbl1 (
    .i_clk, .i_rst, .i_p(i_p1), .i_val(i_val1), .o_rdy(o_rdy1),
    .o_p(o_p1), .o_val(o_val1), .i_rdy(i_rdy1),
    .o_req(req1), .o_req_val(req_val1), .i_req_rdy(req_rdy1),
    .i_rsp(arb_rsp), .i_rsp_val(rsp_val1)
  );

  mult_arbiter u_arb (
    .i_clk, .i_rst,
    .i_req0(req0), .i_req1(req1), .i_val0(req_val0), .i_val1(req_val1),
    .o_rdy0(req_rdy0), .o_rdy1(req_rdy1),
    .o_req(arb_req), .o_val(arb_val), .i_rdy(mul_rdy),
    .i_rsp(mul_rsp), .i_rsp_val(mul_rsp_val),
    .o_rsp(arb_rsp), .o_rsp_val0(rsp_val0), .o_rsp_val1(rsp_val1)
  );

  mod_mult u_mul (
    .i_clk, .i_rst, .i_req(arb_req), .i_val(arb_val), .o_rdy(mul_rdy),
    .o_rsp(mul_rsp), .o_rsp_val(mul_rsp_val)
  );

endmodule

/* test/ecc_dbl_props.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and reset rules, bound into ecc_dbl_top
// Relies on the internal net names of ecc_dbl_top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ecc_dbl_props
  import ecc_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst,
  input mul_req_t  i_req0,
  input logic      i_req_val0,
  input logic      i_req_rdy0,
  input mul_req_t  i_req1,
  input logic      i_req_val1,
  input logic      i_req_rdy1,
  input logic      i_rsp_val0,
  input logic      i_rsp_val1,
  input jb_point_t i_res0,
  input logic      i_res_val0,
  input logic      i_res_rdy0,
  input jb_point_t i_res1,
  input logic      i_res_val1,
  input logic      i_res_rdy1
);

  req_id_t owner;  // Engine whose request the multiplier took last

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      owner <= 1'b0;
    end else if (i_req_val0 && i_req_rdy0) begin
      owner <= 1'b0;
    end else if (i_req_val1 && i_req_rdy1) begin
      owner <= 1'b1;
    end
  end

  // A request that is not taken keeps its valid and operands
  a_req_hold0: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req_val0 && !i_req_rdy0 |=> i_req_val0 && $stable(i_req0))
    else $error("engine 0 changed its multiplier request while waiting");
  a_req_hold1: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req_val1 && !i_req_rdy1 |=> i_req_val1 && $stable(i_req1))
    else $error("engine 1 changed its multiplier request while waiting");

  // Strobe only to the engine that issued, so never both at once
  a_rsp_own0: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rsp_val0 |-> owner == 1'b0)
    else $error("response strobe went to engine 0 for a request of engine 1");
  a_rsp_own1: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rsp_val1 |-> owner == 1'b1)
    else $error("response strobe went to engine 1 for a request of engine 0");

  // Result held until the sink takes it
  a_res_hold0: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_val0 && !i_res_rdy0 |=> i_res_val0 && $stable(i_res0))
    else $error("port 0 result changed or dropped before transfer");
  a_res_hold1: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_val1 && !i_res_rdy1 |=> i_res_val1 && $stable(i_res1))
    else $error("port 1 result changed or dropped before transfer");

  a_rst_quiet: assert property (@(posedge i_clk) i_rst |=>
    !(i_req_val0 || i_req_val1 || i_rsp_val0 || i_rsp_val1 || i_res_val0 || i_res_val1))
    else $error("a valid was high during reset");

endmodule

bind ecc_dbl_top ecc_dbl_props u_props (
  .i_clk, .i_rst,
  .i_req0(req0), .i_req_val0(req_val0), .i_req_rdy0(req_rdy0),
  .i_req1(req1), .i_req_val1(req_val1), .i_req_rdy1(req_rdy1),
  .i_rsp_val0(rsp_val0), .i_rsp_val1(rsp_val1),
  .i_res0(o_p0), .i_res_val0(o_val0), .i_res_rdy0(i_rdy0),
  .i_res1(o_p1), .i_res_val1(o_val1), .i_res_rdy1(i_rdy1)
);

/* test/tb_ecc_dbl.sv */
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for ecc_dbl_top, run from the project root
// Vectors in test/dbl_vectors.hex, six 256-bit words per record
// Expected points there follow the Jacobian doubling formulas mod p
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_ecc_dbl
  import ecc_pkg::*;
();

  localparam int N_REC   = 3;   // Records in the vector file
  localparam int N_PTS   = 11;  // Points sent over all phases
  // Seven products of 258 cycles per point, doubled for sharing, plus slack
  localparam int MAX_CYC = N_PTS * 7 * 258 * 2 + 1000;

  logic       clk, rst;
  jb_point_t  in_p [2];
  jb_point_t  out_p [2];
  logic [1:0] in_val, out_rdy, out_val, sink_rdy;
  fe_t        vec_mem [N_REC*6];
  jb_point_t  exp_q0 [$];   // Outstanding results of port 0, send order
  jb_point_t  exp_q1 [$];
  jb_point_t  held_p [2];   // Output seen in a stalled cycle
  logic [1:0] stalled;
  logic       rand_rdy;     // Sink ready follows the LFSR
  logic [7:0] lfsr_q;
  int         errors, n_done, cyc;

  ecc_dbl_top dut (
    .i_clk(clk), .i_rst(rst),
    .i_p0(in_p[0]), .i_val0(in_val[0]), .o_rdy0(out_rdy[0]),
    .o_p0(out_p[0]), .o_val0(out_val[0]), .i_rdy0(sink_rdy[0]),
    .i_p1(in_p[1]), .i_val1(in_val[1]), .o_rdy1(out_rdy[1]),
    .o_p1(out_p[1]), .o_val1(out_val[1]), .i_rdy1(sink_rdy[1])
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // 8-bit Fibonacci LFSR, taps 8 6 5 4, one step per bit
  function automatic logic take_bit();
    lfsr_q = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    return lfsr_q[0];
  endfunction

  // Half 0 is the input point, half 1 the expected result
  function automatic jb_point_t rec_point(input int r, input int half);
    int base;
    base = 6 * r + 3 * half;
    return {vec_mem[base], vec_mem[base+1], vec_mem[base+2]};
  endfunction

  task automatic check_fe(input string what, input fe_t exp, input fe_t got);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_point(input string what, input jb_point_t exp, input jb_point_t got);
    check_fe({what, " x"}, exp.x, got.x);
    check_fe({what, " y"}, exp.y, got.y);
    check_fe({what, " z"}, exp.z, got.z);
  endtask

  // Called mid-cycle, so v && r here means a transfer on the next edge
  task automatic watch_port(input int port, input jb_point_t p, input logic v,
                            input logic r);
    jb_point_t exp;
    int        left;
    if (stalled[port] && !v) begin
      errors++;
      $display("Port %0d dropped o_val at %0t ns before its result was taken", port, $time);
    end else if (stalled[port]) begin
      check_point($sformatf("port %0d held output", port), held_p[port], p);
    end
    stalled[port] = v && !r;
    held_p[port]  = p;
    if (v && r) begin
      left = (port == 0) ? exp_q0.size() : exp_q1.size();
      if (left == 0) begin
        errors++;
        $display("Port %0d gave a result at %0t ns with none outstanding", port, $time);
      end else begin
        if (port == 0) exp = exp_q0.pop_front();
        else exp = exp_q1.pop_front();
        check_point($sformatf("port %0d result %0d", port, n_done), exp, p);
        n_done++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      watch_port(0, out_p[0], out_val[0], sink_rdy[0]);
      watch_port(1, out_p[1], out_val[1], sink_rdy[1]);
    end
  end

  always @(posedge clk) begin
    #1;
    if (rand_rdy) begin
      sink_rdy[0] = take_bit();
      sink_rdy[1] = take_bit();
    end
  end

  // Offer one record on a port, hold it until o_rdy takes it
  task automatic send_point(input int port, input int rec);
    jb_point_t pt;
    logic      took;
    pt = rec_point(rec, 0);
    @(posedge clk);
    #1;
    in_p[port]   = pt;
    in_val[port] = 1'b1;
    if (port == 0) exp_q0.push_back(rec_point(rec, 1));
    else exp_q1.push_back(rec_point(rec, 1));
    took = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = out_rdy[port];
      @(posedge clk);
      #1;
    end
    in_val[port] = 1'b0;
    if (pt.z == '0) begin  // Infinity must show up one cycle after acceptance
      @(negedge clk);
      if (!out_val[port]) begin
        errors++;
        $display("Port %0d did not return the infinity point on the next cycle", port);
      end
    end
  endtask

  task automatic wait_drained();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge clk);
  endtask

  initial begin : watchdog
    cyc = 0;
    while (cyc < MAX_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("Run timed out after %0d cycles with results still missing", cyc);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    rst      = 1'b1;
    in_p[0]  = '0;
    in_p[1]  = '0;
    in_val   = 2'b00;
    sink_rdy = 2'b00;
    rand_rdy = 1'b0;
    lfsr_q   = 8'd39;  // Seed
    stalled  = 2'b00;
    errors   = 0;
    n_done   = 0;
    $readmemh("test/dbl_vectors.hex", vec_mem);
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;

    repeat (2) begin  // Quiet outputs, ready within two cycles
      @(negedge clk);
      if (out_val != 2'b00) begin
        errors++;
        $display("An o_val was high at %0t ns right after reset", $time);
      end
    end
    if (out_rdy != 2'b11) begin
      errors++;
      $display("o_rdy was not high within two cycles of reset release");
    end

    @(posedge clk);
    #1;
    sink_rdy = 2'b11;
    send_point(0, 0);  // Port 0 alone
    wait_drained();

    fork  // Both engines share the multiplier
      send_point(0, 1);
      send_point(1, 0);
    join
    wait_drained();

    fork
      send_point(0, 2);
      send_point(1, 2);
    join
    wait_drained();

    rand_rdy = 1'b1;  // Back-pressure from here on
    fork
      begin
        send_point(0, 1);
        send_point(0, 2);
        send_point(0, 0);
      end
      begin
        send_point(1, 0);
        send_point(1, 2);
        send_point(1, 1);
      end
    join
    wait_drained();
    @(posedge clk);

    if (n_done != N_PTS) begin
      errors++;
      $display("Only %0d of %0d results arrived", n_done, N_PTS);
    end
    $display("Results %0d, errors %0d", n_done, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* test/dbl_vectors.hex */
// One 256-bit word per line, six lines per record
// Input x y z, then expected doubled x y z
3
5
7
81
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFEFFFFFAB0
46
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFEFFFFFC2B
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFEFFFFFC2C
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFEFFFFFC2D
A20
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFEFFFDF8A7
C
7
B
0
7
B
0

/* src.f */
design/ecc_pkg.sv
design/mod_mult.sv
design/mult_arbiter.sv
design/point_dbl.sv
design/ecc_dbl_top.sv
test/ecc_dbl_props.sv
test/tb_ecc_dbl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_ecc_dbl -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  exit 1
fi
